//--- source/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// instruction and register file geometry
`define INST_W      32
`define REG_ADDR_W  5

// apb bus widths
`define APB_ADDR_W  8
`define APB_DATA_W  32

// event counter width
`define CNT_W       16

// register map
`define REG_INST    8'h00   // write only
`define REG_CTRL    8'h04
`define REG_REGS    8'h08
`define REG_STATUS  8'h0C
`define REG_DEC_CNT 8'h10
`define REG_ILL_CNT 8'h14

// system encoding that halts the unit
`define EBREAK_WORD 32'h0010_0073

`endif

//--- source/rv_decode_pkg.sv
`include "rv_decode_params.svh"
`default_nettype none

package rv_decode_pkg;

    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_system    = 7'b1110011
    } opcode_e;

    typedef enum logic [4:0] {
        alu_none, alu_add, alu_sub, alu_mul, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra,
        alu_divu, alu_remu, alu_div, alu_rem,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg, src_imm, src_pc_plus4, src_imm_pc
    } alu_src_e;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt
    } imm_sel_e;

    typedef enum logic [3:0] {
        mem_none, mem_lb_u, mem_lh, mem_lh_u, mem_lw, mem_ld,
        mem_sb, mem_sh, mem_sw, mem_sd
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle, st_decode, st_halted
    } fsm_state_e;

    typedef struct packed {
        logic     illegal;
        logic     ebreak;
        logic     reg_wen;
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     word_op;   // 32-bit groups
        logic     mul;
        alu_op_e  alu_op;
        alu_src_e alu_src;
        imm_sel_e imm_sel;
        mem_op_e  mem_op;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
    } reg_addrs_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module inst_decoder import rv_decode_pkg::*; (
    input  logic [`INST_W-1:0] inst,
    output decode_ctrl_t       ctrl,
    output reg_addrs_t         regs
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic                   legal;
    logic                   use_rs1;
    logic                   use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl    = '0;
        legal   = 1'b1;
        use_rs1 = 1'b1;   // dropped for lui, auipc, jal
        use_rs2 = 1'b0;
        case (opcode)
            opc_op: begin
                ctrl.reg_wen = 1'b1;
                use_rs2      = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000001, 3'b000}: begin
                        ctrl.alu_op = alu_mul;
                        ctrl.mul    = 1'b1;
                    end
                    {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000001, 3'b101}: ctrl.alu_op = alu_divu;
                    {7'b0000001, 3'b111}: ctrl.alu_op = alu_remu;
                    default:              legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_imm;
                ctrl.imm_sel = imm_i;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b001, 3'b101: begin
                        ctrl.alu_op  = (funct3 == 3'b001) ? alu_sll : alu_srl;
                        ctrl.imm_sel = imm_shamt;
                        legal        = (inst[31:26] == 6'b0);   // 6-bit shamt on rv64
                    end
                    default: legal = 1'b0;
                endcase
            end
            opc_op_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                use_rs2      = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000001, 3'b000}: begin
                        ctrl.alu_op = alu_mul;
                        ctrl.mul    = 1'b1;
                    end
                    {7'b0000000, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'b0000000, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'b0100000, 3'b101}: ctrl.alu_op = alu_sra;
                    {7'b0000001, 3'b100}: ctrl.alu_op = alu_div;
                    {7'b0000001, 3'b110}: ctrl.alu_op = alu_rem;
                    default:              legal = 1'b0;
                endcase
            end
            opc_op_imm_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                ctrl.alu_src = src_imm;
                ctrl.imm_sel = imm_shamt;
                case (funct3)
                    3'b000: begin
                        ctrl.alu_op  = alu_add;
                        ctrl.imm_sel = imm_i;
                    end
                    3'b001: begin
                        ctrl.alu_op = alu_sll;
                        legal       = (funct7 == 7'b0);
                    end
                    3'b101: begin
                        case (funct7)
                            7'b0000000: ctrl.alu_op = alu_srl;
                            7'b0100000: ctrl.alu_op = alu_sra;
                            default:    legal = 1'b0;
                        endcase
                    end
                    default: legal = 1'b0;
                endcase
            end
            opc_load: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_add;   // base + offset
                ctrl.alu_src = src_imm;
                ctrl.imm_sel = imm_i;
                case (funct3)
                    3'b001:  ctrl.mem_op = mem_lh;
                    3'b010:  ctrl.mem_op = mem_lw;
                    3'b011:  ctrl.mem_op = mem_ld;
                    3'b100:  ctrl.mem_op = mem_lb_u;
                    3'b101:  ctrl.mem_op = mem_lh_u;
                    default: legal = 1'b0;
                endcase
            end
            opc_store: begin
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_imm;
                ctrl.imm_sel = imm_s;
                use_rs2      = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_op = mem_sb;
                    3'b001:  ctrl.mem_op = mem_sh;
                    3'b010:  ctrl.mem_op = mem_sw;
                    3'b011:  ctrl.mem_op = mem_sd;
                    default: legal = 1'b0;
                endcase
            end
            opc_branch: begin
                ctrl.branch  = 1'b1;
                ctrl.imm_sel = imm_b;
                use_rs2      = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_beq;
                    3'b001:  ctrl.alu_op = alu_bne;
                    3'b100:  ctrl.alu_op = alu_blt;
                    3'b101:  ctrl.alu_op = alu_bge;
                    3'b110:  ctrl.alu_op = alu_bltu;
                    3'b111:  ctrl.alu_op = alu_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            opc_jal: begin
                ctrl.jump    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_pc_plus4;   // link value
                ctrl.imm_sel = imm_j;
                use_rs1      = 1'b0;
            end
            opc_jalr: begin
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_pc_plus4;
                ctrl.imm_sel = imm_i;
                legal        = (funct3 == 3'b000);
            end
            opc_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_imm;
                ctrl.imm_sel = imm_u;
                use_rs1      = 1'b0;
            end
            opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_imm_pc;
                ctrl.imm_sel = imm_u;
                use_rs1      = 1'b0;
            end
            opc_system: begin
                use_rs1 = 1'b0;
                if (inst == `EBREAK_WORD) begin
                    ctrl.ebreak = 1'b1;
                end else begin
                    legal = 1'b0;   // ecall, csr ops not supported
                end
            end
            default: legal = 1'b0;
        endcase

        if (!legal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
            use_rs1      = 1'b0;
            use_rs2      = 1'b0;
        end

        regs.rd  = ctrl.reg_wen ? rd : '0;
        regs.rs1 = use_rs1 ? rs1 : '0;
        regs.rs2 = use_rs2 ? rs2 : '0;
    end

endmodule

`default_nettype wire

//--- source/decode_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module decode_seq_fsm import rv_decode_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_write,
    input  logic       is_ebreak,
    input  logic       halt_clear,
    output fsm_state_e state,
    output logic       capture,
    output logic       reject
);

    fsm_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (inst_write) begin
                    state_nxt = st_decode;
                end
            end
            st_decode: begin
                // second access cycle, transfer completes here
                if (!capture) begin
                    state_nxt = is_ebreak ? st_halted : st_idle;
                end
            end
            st_halted: begin
                if (halt_clear) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            capture <= 1'b0;
            reject  <= 1'b0;
        end else begin
            state   <= state_nxt;
            capture <= (state == st_idle) && inst_write;     // high in first access cycle
            reject  <= (state == st_halted) && inst_write;   // submit while halted
        end
    end

endmodule

`default_nettype wire

//--- source/decode_counters.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module decode_counters import rv_decode_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              capture,
    input  logic              is_illegal,
    input  logic              cnt_clear,
    output logic [`CNT_W-1:0] dec_cnt,
    output logic [`CNT_W-1:0] ill_cnt
);

    // increment that sticks at all ones
    function automatic logic [`CNT_W-1:0] sat_inc(input logic [`CNT_W-1:0] value);
        logic [`CNT_W-1:0] result;
        result = value;
        if (value != '1) begin
            result = value + 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_cnt <= '0;
            ill_cnt <= '0;
        end else if (cnt_clear) begin
            dec_cnt <= '0;
            ill_cnt <= '0;
        end else if (capture) begin
            dec_cnt <= sat_inc(dec_cnt);
            if (is_illegal) begin
                ill_cnt <= sat_inc(ill_cnt);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/apb_decode_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module apb_decode_regs import rv_decode_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,
    output logic [`INST_W-1:0] inst,
    input  decode_ctrl_t       dec_ctrl,
    input  reg_addrs_t         dec_regs,
    input  fsm_state_e         state,
    input  logic               capture,
    input  logic               reject,
    input  logic [`CNT_W-1:0]  dec_cnt,
    input  logic [`CNT_W-1:0]  ill_cnt,
    output logic               inst_write,
    output logic               halt_clear,
    output logic               cnt_clear
);

    logic         setup;
    logic         access;
    logic         status_wr;
    decode_ctrl_t ctrl_q;
    reg_addrs_t   regs_q;
    logic         illegal_seen;

    assign setup  = apb_req.psel && !apb_req.penable;
    assign access = apb_req.psel && apb_req.penable;

    assign inst_write = setup && apb_req.pwrite && (apb_req.paddr == `REG_INST);
    assign status_wr  = access && apb_req.pwrite && (apb_req.paddr == `REG_STATUS);
    assign halt_clear = status_wr && apb_req.pwdata[0];
    assign cnt_clear  = status_wr && apb_req.pwdata[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst <= '0;
        end else if (inst_write && state == st_idle) begin   // held while halted
            inst <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '0;
            regs_q <= '0;
        end else if (capture) begin
            ctrl_q <= dec_ctrl;
            regs_q <= dec_regs;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            illegal_seen <= 1'b0;
        end else if (halt_clear) begin
            illegal_seen <= 1'b0;
        end else if (capture && dec_ctrl.illegal) begin
            illegal_seen <= 1'b1;   // sticky
        end
    end

    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = access && !(state == st_decode && capture);   // one wait on submit
        apb_rsp.pslverr = access && reject;
        case (apb_req.paddr)
            `REG_CTRL:    apb_rsp.prdata = `APB_DATA_W'(ctrl_q);
            `REG_REGS:    apb_rsp.prdata = `APB_DATA_W'(regs_q);
            `REG_STATUS:  apb_rsp.prdata = `APB_DATA_W'({illegal_seen, state == st_halted});
            `REG_DEC_CNT: apb_rsp.prdata = `APB_DATA_W'(dec_cnt);
            `REG_ILL_CNT: apb_rsp.prdata = `APB_DATA_W'(ill_cnt);
            default:      apb_rsp.prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module rv_decode_top import rv_decode_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [`INST_W-1:0] inst;
    decode_ctrl_t       dec_ctrl;
    reg_addrs_t         dec_regs;
    fsm_state_e         state;
    logic               capture;
    logic               reject;
    logic               inst_write;
    logic               halt_clear;
    logic               cnt_clear;
    logic [`CNT_W-1:0]  dec_cnt;
    logic [`CNT_W-1:0]  ill_cnt;

    inst_decoder i_decoder (
        .inst (inst),
        .ctrl (dec_ctrl),
        .regs (dec_regs)
    );

    decode_seq_fsm i_seq_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_write (inst_write),
        .is_ebreak  (dec_ctrl.ebreak),
        .halt_clear (halt_clear),
        .state      (state),
        .capture    (capture),
        .reject     (reject)
    );

    decode_counters i_counters (
        .clk        (clk),
        .arst_n     (arst_n),
        .capture    (capture),
        .is_illegal (dec_ctrl.illegal),
        .cnt_clear  (cnt_clear),
        .dec_cnt    (dec_cnt),
        .ill_cnt    (ill_cnt)
    );

    apb_decode_regs i_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .inst       (inst),
        .dec_ctrl   (dec_ctrl),
        .dec_regs   (dec_regs),
        .state      (state),
        .capture    (capture),
        .reject     (reject),
        .dec_cnt    (dec_cnt),
        .ill_cnt    (ill_cnt),
        .inst_write (inst_write),
        .halt_clear (halt_clear),
        .cnt_clear  (cnt_clear)
    );

endmodule

`default_nettype wire

//--- verification/rv_decode_tb_checks.svh
`ifndef RV_DECODE_TB_CHECKS_SVH
`define RV_DECODE_TB_CHECKS_SVH

localparam int n_legal = 18;

// fence, amo, op-fp and an all-ones opcode, none of them decoded here
localparam logic [27:0] unused_opcodes = {7'h7F, 7'h53, 7'h2F, 7'h0F};

typedef struct packed {
    logic [31:0]  base;   // funct7, funct3 and opcode, register fields zero
    logic [1:0]   uses;   // {rs1, rs2}
    decode_ctrl_t ctrl;
} legal_row_t;

string legal_name [n_legal] = '{
    "add", "mul", "remu", "sltu", "srli", "xori", "sraw", "mulw", "sraiw",
    "addiw", "ld", "lhu", "sd", "bgeu", "jal", "jalr", "lui", "auipc"
};

// flags are {illegal, ebreak, reg_wen, branch, jump, jalr, word_op, mul}
function automatic decode_ctrl_t make_ctrl(input logic [7:0] flags, input alu_op_e alu,
                                           input alu_src_e src, input imm_sel_e imm,
                                           input mem_op_e mem);
    return {flags, alu, src, imm, mem};
endfunction

function automatic legal_row_t row(input logic [31:0] base, input logic [1:0] uses,
                                   input logic [7:0] flags, input alu_op_e alu,
                                   input alu_src_e src, input imm_sel_e imm,
                                   input mem_op_e mem);
    legal_row_t r;
    r.base = base;
    r.uses = uses;
    r.ctrl = make_ctrl(flags, alu, src, imm, mem);
    return r;
endfunction

function automatic legal_row_t legal_row(input int idx);
    case (idx)
        0:  return row(32'h0000_0033, 2'b11, 8'b0010_0000, alu_add, src_reg, imm_none, mem_none);
        1:  return row(32'h0200_0033, 2'b11, 8'b0010_0001, alu_mul, src_reg, imm_none, mem_none);
        2:  return row(32'h0200_7033, 2'b11, 8'b0010_0000, alu_remu, src_reg, imm_none, mem_none);
        3:  return row(32'h0000_3033, 2'b11, 8'b0010_0000, alu_sltu, src_reg, imm_none, mem_none);
        4:  return row(32'h0000_5013, 2'b10, 8'b0010_0000, alu_srl, src_imm, imm_shamt, mem_none);
        5:  return row(32'h0000_4013, 2'b10, 8'b0010_0000, alu_xor, src_imm, imm_i, mem_none);
        6:  return row(32'h4000_503B, 2'b11, 8'b0010_0010, alu_sra, src_reg, imm_none, mem_none);
        7:  return row(32'h0200_003B, 2'b11, 8'b0010_0011, alu_mul, src_reg, imm_none, mem_none);
        8:  return row(32'h4000_501B, 2'b10, 8'b0010_0010, alu_sra, src_imm, imm_shamt, mem_none);
        9:  return row(32'h0000_001B, 2'b10, 8'b0010_0010, alu_add, src_imm, imm_i, mem_none);
        10: return row(32'h0000_3003, 2'b10, 8'b0010_0000, alu_add, src_imm, imm_i, mem_ld);
        11: return row(32'h0000_5003, 2'b10, 8'b0010_0000, alu_add, src_imm, imm_i, mem_lh_u);
        12: return row(32'h0000_3023, 2'b11, 8'b0000_0000, alu_add, src_imm, imm_s, mem_sd);
        13: return row(32'h0000_7063, 2'b11, 8'b0001_0000, alu_bgeu, src_reg, imm_b, mem_none);
        14: return row(32'h0000_006F, 2'b00, 8'b0010_1000, alu_add, src_pc_plus4, imm_j, mem_none);
        15: return row(32'h0000_0067, 2'b10, 8'b0010_1100, alu_add, src_pc_plus4, imm_i, mem_none);
        16: return row(32'h0000_0037, 2'b00, 8'b0010_0000, alu_add, src_imm, imm_u, mem_none);
        17: return row(32'h0000_0017, 2'b00, 8'b0010_0000, alu_add, src_imm_pc, imm_u, mem_none);
        default: return '0;
    endcase
endfunction

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
        stop_with_error($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                                  test, expected, actual));
    end
endtask

task automatic expect_reg(input logic [7:0] addr, input logic [31:0] expected, input string test);
    logic [31:0] actual;
    apb_read(addr, actual);
    check_value(test, expected, actual);
endtask

`endif

//--- verification/rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module rv_decode_tb import rv_decode_pkg::*; ();

    logic        clk;
    logic        arst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [15:0] lfsr_state;
    int          exp_dec;
    int          exp_ill;
    int          cycle_cnt;

    `include "rv_decode_tb_checks.svh"

    localparam int n_illegal      = 4;
    localparam int n_tracked      = 3;
    localparam int xfer_max       = 3;   // setup plus two access cycles
    localparam int test_xfers     = 5 + 3 * n_legal + 6 * n_illegal + 13 + 4 + 4 * n_tracked;
    localparam int timeout_cycles = 2 * (9 + xfer_max * test_xfers);

    rv_decode_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= timeout_cycles) begin
                stop_with_error($sformatf("timed out after %0d cycles", cycle_cnt));
            end
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] value);
        return value[0] ? ((value >> 1) ^ 16'hB400) : (value >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // called just after a rising edge, returns just after the completing edge
    task automatic apb_xfer(input logic is_write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = is_write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_xfer(1'b0, addr, '0, data, err, waits);
        check_value($sformatf("read 0x%02h wait states", addr), 0, waits);
        check_value($sformatf("read 0x%02h pslverr", addr), 0, {31'b0, err});
    endtask

    task automatic status_write(input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b1, `REG_STATUS, data, rdata, err, waits);
        check_value("status write wait states", 0, waits);
    endtask

    task automatic submit(input logic [31:0] word, input logic accepted, input string test);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b1, `REG_INST, word, rdata, err, waits);
        check_value({test, " pslverr"}, {31'b0, !accepted}, {31'b0, err});
        check_value({test, " wait states"}, accepted ? 1 : 0, waits);
        if (accepted) begin
            exp_dec++;
        end
    endtask

    task automatic run_legal(input int idx);
        legal_row_t  entry;
        logic [31:0] fields;
        reg_addrs_t  exp_regs;
        entry = legal_row(idx);
        take_bits(15, fields);   // rd, rs1, rs2
        exp_regs.rd  = entry.ctrl.reg_wen ? fields[14:10] : 5'd0;
        exp_regs.rs1 = entry.uses[1] ? fields[9:5] : 5'd0;
        exp_regs.rs2 = entry.uses[0] ? fields[4:0] : 5'd0;
        submit(entry.base | {7'b0, fields[4:0], fields[9:5], 3'b0, fields[14:10], 7'b0},
               1'b1, legal_name[idx]);
        expect_reg(`REG_CTRL, 32'(entry.ctrl), {legal_name[idx], " ctrl"});
        expect_reg(`REG_REGS, 32'(exp_regs), {legal_name[idx], " regs"});
    endtask

    task automatic run_illegal();
        logic [31:0] body;
        logic [31:0] pick;
        logic [31:0] word;
        take_bits(25, body);
        take_bits(2, pick);
        word = {body[24:0], unused_opcodes[pick[1:0] * 7 +: 7]};
        submit(word, 1'b1, $sformatf("illegal 0x%08h", word));
        exp_ill++;
        expect_reg(`REG_CTRL, 32'(make_ctrl(8'b1000_0000, alu_none, src_reg, imm_none,
                   mem_none)), $sformatf("illegal 0x%08h ctrl", word));
        expect_reg(`REG_REGS, 0, $sformatf("illegal 0x%08h regs", word));
        expect_reg(`REG_DEC_CNT, exp_dec, "decoded count");
        expect_reg(`REG_ILL_CNT, exp_ill, "illegal count");
        expect_reg(`REG_STATUS, 32'h2, "status illegal_seen");
    endtask

    initial begin
        decode_ctrl_t ebreak_ctrl;
        logic [31:0]  fields;
        int           idx;
        apb_req     = '0;
        arst_n      = 1'b0;
        lfsr_state  = 16'd19688;
        exp_dec     = 0;
        exp_ill     = 0;
        ebreak_ctrl = make_ctrl(8'b0100_0000, alu_none, src_reg, imm_none, mem_none);
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        expect_reg(`REG_CTRL, 0, "reset ctrl");
        expect_reg(`REG_REGS, 0, "reset regs");
        expect_reg(`REG_STATUS, 0, "reset status");
        expect_reg(`REG_DEC_CNT, 0, "reset decoded count");
        expect_reg(`REG_ILL_CNT, 0, "reset illegal count");

        for (idx = 0; idx < n_legal; idx++) begin
            run_legal(idx);
        end
        repeat (n_illegal) begin
            run_illegal();
        end

        submit(`EBREAK_WORD, 1'b1, "ebreak");
        expect_reg(`REG_STATUS, 32'h3, "status after ebreak");
        expect_reg(`REG_CTRL, 32'(ebreak_ctrl), "ebreak ctrl");
        expect_reg(`REG_REGS, 0, "ebreak regs");
        submit(32'h0000_0033, 1'b0, "submit while halted");   // add, must bounce
        expect_reg(`REG_DEC_CNT, exp_dec, "decoded count while halted");
        expect_reg(`REG_ILL_CNT, exp_ill, "illegal count while halted");
        expect_reg(`REG_CTRL, 32'(ebreak_ctrl), "ctrl while halted");
        status_write(32'h1);
        expect_reg(`REG_STATUS, 0, "status after halt clear");
        run_legal(0);

        status_write(32'h2);
        exp_dec = 0;
        exp_ill = 0;
        expect_reg(`REG_DEC_CNT, 0, "decoded count after clear");
        expect_reg(`REG_ILL_CNT, 0, "illegal count after clear");
        repeat (n_tracked) begin
            take_bits(5, fields);
            run_legal(fields % n_legal);
            expect_reg(`REG_DEC_CNT, exp_dec, "decoded count tracking");
        end
        expect_reg(`REG_ILL_CNT, 0, "illegal count tracking");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
+incdir+verification
source/rv_decode_pkg.sv
source/inst_decoder.sv
source/decode_seq_fsm.sv
source/decode_counters.sv
source/apb_decode_regs.sv
source/rv_decode_top.sv
verification/rv_decode_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= rv_decode_tb
RTL_TOP    ?= rv_decode_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
SIM_FLAGS  ?= --binary --assert --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
